// File: sources.f
bch_field_pkg.sv
bch_code_pkg.sv
codeword_feeder.sv
syndrome_accum.sv
syndrome_collector.sv
bch_syndrome_top.sv
syndrome_checker.sv
tb_bch_syndrome.sv

// File: Makefile
# Verilator build and run for the BCH syndrome testbench, started from the project root.
# Any variable below can be set on the command line, e.g. make test LOG=run.log.

VERILATOR ?= verilator
TOP ?= tb_bch_syndrome
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, then search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bch_stim.txt
# columns in hex: codeword (bit i is x^i), expected S1, S3, S5
# valid codewords first, then one, two and three flipped bits
0000 0 0 0
0537 0 0 0
0a6e 0 0 0
5370 0 0 0
7fff 0 0 0
0001 1 1 1
4000 9 f 7
05b7 b c 6
7ff7 8 a 1
5770 7 1 6
2002 f 2 0
087e 9 0 7
3ffe 8 e 6
0844 6 c 1
143f 2 c 7
57d0 a c 7

// File: tb_bch_syndrome.sv
/* Sends every codeword of bch_stim.txt through the syndrome DUT, honouring busy.
   Gaps of 0 to 3 cycles between words come from an 8-bit Galois LFSR. */
`timescale 1ns/1ns

module tb_bch_syndrome;
	import bch_code_pkg::*;

	localparam int half_period = 2; // 4 ns clock.
	localparam int reset_cycles = 3;
	localparam int busy_timeout = 20; // a word takes five cycles, so this is generous.
	localparam int drain_timeout = 50;
	localparam logic [7:0] lfsr_seed = 8'd49;

	logic clk;
	logic reset;
	logic word_valid;
	codeword_t word;
	logic busy;
	logic result_valid;
	syndrome_set_t result;
	logic error_found;

	logic [7:0] lfsr; // taps x^8+x^6+x^5+x^4+1.
	syndrome_set_t exp_syn;
	string line;
	int fd;
	int fields;
	int got;
	int waited;
	int sent;
	int gap;
	int w_in;
	int s1_in;
	int s3_in;
	int s5_in;
	logic ok;
	logic stalled;
	logic file_ok;

	always #half_period clk = ~clk;

	bch_syndrome_top bch_syndrome_top_i (
		.clk(clk),
		.reset(reset),
		.word_valid(word_valid),
		.word(word),
		.busy(busy),
		.result_valid(result_valid),
		.result(result),
		.error_found(error_found)
	);

	syndrome_checker syndrome_checker_i (
		.clk(clk),
		.reset(reset),
		.word_valid(word_valid),
		.busy(busy),
		.result_valid(result_valid),
		.result(result),
		.error_found(error_found)
	);

	// one Galois step, the bit shifted out is the random bit.
	function automatic logic lfsr_step();
		logic out;
		out = lfsr[0];
		lfsr = {1'b0, lfsr[7:1]} ^ (out ? 8'hb8 : 8'h00);
		return out;
	endfunction

	function automatic int next_gap();
		int g;
		g = 0;
		for (int i = 0; i < 2; i++)
			g = (g << 1) | int'(lfsr_step());
		return g;
	endfunction

	// called 1 ns after an edge, where busy is settled.
	task automatic send_word(input codeword_t w, input int idle, output logic sent_ok);
		int cycles;
		cycles = 0;
		while (busy && cycles < busy_timeout) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (busy) begin
			$display("busy stayed high for %0d cycles, word %h not sent", busy_timeout, w);
			sent_ok = 1'b0;
		end else begin
			// idle cycles count from busy low, so zero runs words back to back.
			repeat (idle) begin
				@(posedge clk);
				#1;
			end
			word = w;
			word_valid = 1'b1;
			@(posedge clk);
			#1;
			word_valid = 1'b0; // single cycle strobe.
			sent_ok = 1'b1;
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		word_valid = 1'b0;
		word = '0;
		lfsr = lfsr_seed;
		sent = 0;
		stalled = 1'b0;
		file_ok = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;

		fd = $fopen("bch_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open bch_stim.txt");
			file_ok = 1'b0;
		end else begin
			while (!stalled && !$feof(fd)) begin
				got = $fgets(line, fd);
				fields = 0;
				if (got != 0)
					fields = $sscanf(line, "%h %h %h %h", w_in, s1_in, s3_in, s5_in);
				if (fields == 4) begin // comment and blank lines give fewer fields.
					exp_syn.s1 = s1_in[3:0];
					exp_syn.s3 = s3_in[3:0];
					exp_syn.s5 = s5_in[3:0];
					syndrome_checker_i.expect_result(exp_syn);
					gap = next_gap();
					send_word(w_in[14:0], gap, ok);
					if (!ok)
						stalled = 1'b1;
					else
						sent++;
				end
			end
			$fclose(fd);
		end

		waited = 0;
		while (!stalled && syndrome_checker_i.pending() != 0 && waited < drain_timeout) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (syndrome_checker_i.pending() != 0) begin
			$display("%0d results never arrived", syndrome_checker_i.pending());
			stalled = 1'b1;
		end
		repeat (10) @(posedge clk); // room for a stray extra strobe to show up.

		$display("sent %0d, checked %0d, failed %0d, other errors %0d", sent,
			syndrome_checker_i.tests_done, syndrome_checker_i.tests_failed,
			syndrome_checker_i.protocol_errors);
		if (file_ok && !stalled && sent > 0 && syndrome_checker_i.tests_done == sent &&
			syndrome_checker_i.tests_failed == 0 && syndrome_checker_i.protocol_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: syndrome_checker.sv
/* Watches the syndrome DUT and compares each result strobe with the head of a queue.
   Expected sets are pushed by the testbench through expect_result before each word. */
`timescale 1ns/1ns

module syndrome_checker (
	input logic clk,
	input logic reset,
	input logic word_valid,
	input logic busy,
	input logic result_valid,
	input bch_code_pkg::syndrome_set_t result,
	input logic error_found
);
	import bch_code_pkg::*;

	localparam int result_latency = 7; // edges from accept to the edge that raises result_valid.
	localparam int busy_low_after = 5; // busy is low again before the fifth slice edge.

	syndrome_set_t expected_q [$]; // one entry per word sent, oldest first.
	int accept_q [$]; // edge numbers of accepted strobes.
	int cycle = 0;
	int busy_check_at = -1;
	logic in_reset = 1'b1;
	int tests_done = 0;
	int tests_failed = 0;
	int protocol_errors = 0; // failures that are not a wrong value.

	function automatic void expect_result(input syndrome_set_t syn);
		expected_q.push_back(syn);
	endfunction

	function automatic int pending();
		return expected_q.size();
	endfunction

	// returns 1 and prints the failure when the two values differ.
	function automatic int mismatch(input string name, input int exp_v, input int act_v);
		if (exp_v == act_v)
			return 0;
		$display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
		return 1;
	endfunction

	//////////////////////////////
	// result comparison
	//////////////////////////////

	task automatic check_result();
		syndrome_set_t exp;
		int bad;
		int latency;
		exp = expected_q.pop_front();
		bad = 0;
		bad += mismatch("result.s1", int'(exp.s1), int'(result.s1));
		bad += mismatch("result.s3", int'(exp.s3), int'(result.s3));
		bad += mismatch("result.s5", int'(exp.s5), int'(result.s5));
		bad += mismatch("error_found", int'(|exp), int'(error_found)); // errors iff any S nonzero.
		if (accept_q.size() == 0) begin
			$display("result at %0t has no accepted word_valid behind it", $time);
			bad++;
		end else begin
			latency = cycle - 1 - accept_q.pop_front(); // the strobe seen now was set one edge ago.
			bad += mismatch("result_valid latency", result_latency, latency);
		end
		tests_done++;
		if (bad != 0)
			tests_failed++;
		$display("test %0d: s1=%h s3=%h s5=%h error_found=%b %s", tests_done,
			result.s1, result.s3, result.s5, error_found, (bad == 0) ? "ok" : "wrong");
	endtask

	//////////////////////////////
	// edge monitor
	//////////////////////////////

	always @(posedge clk) begin
		cycle = cycle + 1;
		if (reset) begin
			in_reset = 1'b1;
		end else begin
			if (in_reset && busy) begin // state must be idle straight out of reset.
				$display("busy is high at %0t right after reset", $time);
				protocol_errors++;
			end
			in_reset = 1'b0;
			if (cycle == busy_check_at && busy) begin
				$display("busy still high at %0t when the last slice goes out", $time);
				protocol_errors++;
			end
			if (word_valid && !busy) begin
				accept_q.push_back(cycle);
				busy_check_at = cycle + busy_low_after;
			end
			if (result_valid) begin
				if (expected_q.size() == 0) begin
					$display("result_valid at %0t with no word outstanding", $time);
					protocol_errors++;
				end else begin
					check_result();
				end
			end
		end
	end

endmodule

// File: bch_syndrome_top.sv
/* Odd syndromes of BCH(15,5) over GF(2^4), fixed seven cycle latency per word.
   New words are taken only while busy is low and results are never stalled. */
`timescale 1ns/1ns

module bch_syndrome_top (
	input logic clk,
	input logic reset,
	input logic word_valid,
	input bch_code_pkg::codeword_t word,
	output logic busy,
	output logic result_valid,
	output bch_code_pkg::syndrome_set_t result,
	output logic error_found
);
	import bch_field_pkg::*;
	import bch_code_pkg::*;

	logic chunk_valid;
	chunk_t chunk; // shared by all accumulators.
	gf_elem_t syn [num_syn]; // syn[k] is S_(2k+1).
	syndrome_set_t syndromes;

	codeword_feeder codeword_feeder_i (
		.clk(clk),
		.reset(reset),
		.word_valid(word_valid),
		.word(word),
		.busy(busy),
		.chunk_valid(chunk_valid),
		.chunk(chunk)
	);

	//////////////////////////////
	// one accumulator per odd syndrome
	//////////////////////////////

	for (genvar k = 0; k < num_syn; k++) begin : gen_accum
		syndrome_accum #(
			.syn_index(2 * k + 1)
		) syndrome_accum_i (
			.clk(clk),
			.reset(reset),
			.chunk_valid(chunk_valid),
			.chunk(chunk),
			.syndrome(syn[k])
		);
	end

	assign syndromes = '{s5: syn[2], s3: syn[1], s1: syn[0]};

	syndrome_collector syndrome_collector_i (
		.clk(clk),
		.reset(reset),
		.chunk_valid(chunk_valid),
		.chunk_last(chunk.last),
		.syndromes(syndromes),
		.result_valid(result_valid),
		.result(result),
		.error_found(error_found)
	);

endmodule

// File: syndrome_collector.sv
/* Captures the syndrome set one cycle after the last slice is seen.
   The strobe cannot stall, so the receiver must take each result when it appears. */
`timescale 1ns/1ns

module syndrome_collector (
	input logic clk,
	input logic reset,
	input logic chunk_valid,
	input logic chunk_last,
	input bch_code_pkg::syndrome_set_t syndromes,
	output logic result_valid,
	output bch_code_pkg::syndrome_set_t result,
	output logic error_found
);

	logic capture; // accumulators finished their update on the last edge.

	//////////////////////////////
	// control
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			capture <= 1'b0;
			result_valid <= 1'b0;
			error_found <= 1'b0;
		end else begin
			capture <= chunk_valid && chunk_last; // same edge the last slice is summed.
			result_valid <= capture;
			if (capture)
				error_found <= |syndromes; // any nonzero odd syndrome means errors.
		end
	end

	// result holds until the next capture.
	// The accumulators may already be on the next word by then.
	always_ff @(posedge clk) begin
		if (capture)
			result <= syndromes;
	end

	// last slices are at least five cycles apart, so the strobe is one cycle.
	assert property (@(posedge clk) disable iff (reset) result_valid |=> !result_valid)
		else $error("result_valid held for two cycles");

endmodule

// File: syndrome_accum.sv
/* Horner accumulator for S_j with j = syn_index, one slice per valid cycle.
   The result is final one edge after the last slice and holds until the next start. */
`timescale 1ns/1ns

module syndrome_accum #(
	parameter int syn_index = 1 // odd power of alpha this unit evaluates.
) (
	input logic clk,
	input logic reset,
	input logic chunk_valid,
	input bch_code_pkg::chunk_t chunk,
	output bch_field_pkg::gf_elem_t syndrome
);
	import bch_field_pkg::*;
	import bch_code_pkg::*;

	//////////////////////////////
	// constants
	//////////////////////////////

	// data[b] is the coefficient of beta^b within a slice, beta = alpha^j.
	localparam gf_elem_t bit_weight [chunk_bits] = '{
		gf_alpha_pow(0),
		gf_alpha_pow(syn_index),
		gf_alpha_pow(2 * syn_index)
	};

	// moving the running value past one slice raises it by beta^3.
	localparam gf_elem_t step_weight = gf_alpha_pow(chunk_bits * syn_index);

	gf_elem_t term_sum; // weighted sum of the current slice.
	gf_elem_t carried; // previous value shifted up by one slice.
	logic open_word; // a start has been seen and its last has not.

	//////////////////////////////
	// slice evaluation
	//////////////////////////////

	always_comb begin
		term_sum = '0;
		for (int b = 0; b < chunk_bits; b++) begin
			if (chunk.data[b])
				term_sum ^= bit_weight[b]; // addition in GF(2^m) is XOR.
		end
	end

	assign carried = gf_mul(syndrome, step_weight);

	// S = (...(c0 * beta^3 + c1) * beta^3 + ...) + c4 where c_k is a slice sum.
	always_ff @(posedge clk) begin
		if (chunk_valid) begin
			if (chunk.start)
				syndrome <= term_sum; // a new word drops the old value.
			else
				syndrome <= term_sum ^ carried;
		end
	end

	//////////////////////////////
	// framing check
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			open_word <= 1'b0;
		else if (chunk_valid && chunk.start)
			open_word <= 1'b1;
		else if (chunk_valid && chunk.last)
			open_word <= 1'b0;
	end

	// a word cut short by a fresh start would leave a partial syndrome.
	assert property (@(posedge clk) disable iff (reset)
		(chunk_valid && chunk.start) |-> !open_word)
		else $error("start seen again before last");

endmodule

// File: codeword_feeder.sv
/* Takes one codeword per strobe while busy is low and slices it MSB first.
   A strobe sampled while busy is high is a protocol error. */
`timescale 1ns/1ns

module codeword_feeder (
	input logic clk,
	input logic reset,
	input logic word_valid, // single cycle strobe.
	input bch_code_pkg::codeword_t word,
	output logic busy,
	output logic chunk_valid,
	output bch_code_pkg::chunk_t chunk
);
	import bch_code_pkg::*;

	codeword_t word_sr; // remaining bits, next slice sits at the top.
	logic [$clog2(chunks_per_word)-1:0] chunk_idx; // slice emitted on the next edge.
	logic active; // a word is being sliced.
	logic accept; // strobe taken this cycle.
	logic final_slice; // the coming edge emits the last slice.

	assign final_slice = active && (int'(chunk_idx) == chunks_per_word - 1);

	// busy drops one cycle early so the next word can load on the edge
	// that emits the last slice. Words then run without a gap.
	assign busy = active && !final_slice;
	assign accept = word_valid && !busy;

	//////////////////////////////
	// control
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			chunk_idx <= '0;
			chunk_valid <= 1'b0;
		end else begin
			chunk_valid <= active; // every active cycle emits one slice.
			if (active)
				chunk_idx <= chunk_idx + 1'b1;
			if (final_slice)
				active <= 1'b0;
			if (accept) begin // a new word overrides the end of the old one.
				active <= 1'b1;
				chunk_idx <= '0;
			end
		end
	end

	//////////////////////////////
	// datapath
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (accept)
			word_sr <= word;
		else if (active)
			word_sr <= word_sr << chunk_bits; // move the next slice to the top.
		if (active) begin
			chunk.data <= word_sr[code_n-1 -: chunk_bits];
			chunk.start <= (chunk_idx == '0);
			chunk.last <= final_slice;
		end
	end

	// the source must wait for busy low before it strobes.
	assert property (@(posedge clk) disable iff (reset) word_valid |-> !busy)
		else $error("word_valid sampled while busy");

endmodule

// File: bch_code_pkg.sv
/* Sizes and bus structs for the BCH(15,5) t=3 syndrome path.
   Only odd syndromes are carried since even ones follow from them. */

package bch_code_pkg;

	import bch_field_pkg::*;

	//////////////////////////////
	// code sizes
	//////////////////////////////

	localparam int code_n = 15; // codeword length.
	localparam int code_t = 3; // errors the code corrects.
	localparam int chunk_bits = 3; // received bits consumed per cycle.
	localparam int chunks_per_word = code_n / chunk_bits; // five chunks.
	localparam int num_syn = code_t; // S1, S3 and S5.

	// bit i holds the coefficient of x^i.
	typedef logic [code_n-1:0] codeword_t;

	//////////////////////////////
	// bus structs
	//////////////////////////////

	// one slice of a codeword, highest degree in data[chunk_bits-1].
	typedef struct packed {
		logic [chunk_bits-1:0] data; // received bits of this slice.
		logic start; // first slice of a word.
		logic last; // final slice, holds degrees 2 down to 0.
	} chunk_t;

	// the odd syndromes of one codeword.
	typedef struct packed {
		gf_elem_t s5;
		gf_elem_t s3;
		gf_elem_t s1;
	} syndrome_set_t;

endpackage

// File: bch_field_pkg.sv
/* GF(2^4) arithmetic for the BCH(15,5) syndrome path, fixed to x^4+x+1.
   Other fields need a new antilog table and polynomial. */

package bch_field_pkg;

	//////////////////////////////
	// field constants
	//////////////////////////////

	localparam int gf_m = 4; // bits per field element.
	localparam int gf_n = 15; // alpha has order 2^m - 1.
	localparam logic [gf_m:0] gf_poly = 5'b10011; // x^4 + x + 1.

	typedef logic [gf_m-1:0] gf_elem_t;

	// alpha^i in polynomial basis, bit k is the coefficient of alpha^k.
	localparam gf_elem_t gf_antilog [gf_n] = '{
		4'h1, 4'h2, 4'h4, 4'h8, // alpha^0 .. alpha^3.
		4'h3, 4'h6, 4'hc, 4'hb, // alpha^4 .. alpha^7.
		4'h5, 4'ha, 4'h7, 4'he, // alpha^8 .. alpha^11.
		4'hf, 4'hd, 4'h9 // alpha^12 .. alpha^14.
	};

	//////////////////////////////
	// field functions
	//////////////////////////////

	// any non-negative exponent is folded back into the order of alpha.
	function automatic gf_elem_t gf_alpha_pow(input int unsigned exponent);
		return gf_antilog[exponent % gf_n];
	endfunction

	// plain shift and add multiply.
	// the partial product is reduced after every shift so it never grows past m+1 bits.
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t prod;
		logic [gf_m:0] shifted;
		prod = '0;
		shifted = {1'b0, a};
		for (int i = 0; i < gf_m; i++) begin
			if (b[i])
				prod ^= shifted[gf_m-1:0]; // add a * x^i.
			shifted = shifted << 1;
			if (shifted[gf_m])
				shifted ^= gf_poly; // x^4 folds back to x + 1.
		end
		return prod;
	endfunction

endpackage
